// File: route_pkg.sv
package route_pkg;

    localparam int NODE_ID_WIDTH = 4;

    typedef logic [NODE_ID_WIDTH-1:0] node_id_t;

    // Nodes sit on a line, so a packet either stays here or moves one way.
    typedef enum logic [1:0] {
        PORT_LOCAL = 2'd0,
        PORT_EAST  = 2'd1,
        PORT_WEST  = 2'd2
    } out_port_t;

    function automatic out_port_t route_port(node_id_t dest, node_id_t node_id);
        out_port_t port;
        if (dest == node_id) begin
            port = PORT_LOCAL;
        end else if (dest > node_id) begin
            port = PORT_EAST; // Higher ids lie to the east.
        end else begin
            port = PORT_WEST;
        end
        return port;
    endfunction

endpackage

// File: flit_pkg.sv
package flit_pkg;

    localparam int FLIT_WIDTH       = 32;
    localparam int PKT_LENGTH_WIDTH = 4;

    // Whatever the head layout does not claim is left to a free tag field.
    localparam int TAG_WIDTH = FLIT_WIDTH - 2 * route_pkg::NODE_ID_WIDTH - PKT_LENGTH_WIDTH;

    typedef logic [PKT_LENGTH_WIDTH-1:0] pkt_len_t;

    typedef struct packed {
        route_pkg::node_id_t  dest;   // Destination node.
        route_pkg::node_id_t  src;    // Source node.
        pkt_len_t             length; // Flits in the packet, head included.
        logic [TAG_WIDTH-1:0] tag;
    } head_flit_t;

    typedef struct packed {
        logic [FLIT_WIDTH-1:0] data;
    } body_flit_t;

    // There is no type bit on the wire.
    // The head is recognized by counting flits within the packet.
    typedef union packed {
        head_flit_t head;
        body_flit_t body;
    } flit_t;

    // A length field of zero is read as a single-flit packet.
    function automatic pkt_len_t expected_num_flits(flit_t flit);
        pkt_len_t len;
        len = flit.head.length;
        if (len == '0) begin
            len = pkt_len_t'(1);
        end
        return len;
    endfunction

endpackage

// File: flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo #(
    parameter int DEPTH = 16
) (
    input  logic           CLK,
    input  logic           nRST,
    input  logic           wen,
    input  logic           ren,
    input  flit_pkg::flit_t wdata,
    output flit_pkg::flit_t rdata,
    output logic           empty,
    output logic           full
);

    localparam int ADDR_W = $clog2(DEPTH);

    flit_pkg::flit_t   mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              do_write;
    logic              do_read;

    assign do_write = wen && !full; // A write into a full FIFO is dropped.
    assign do_read  = ren && !empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1; // Pointers wrap since DEPTH is a power of two.
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr]; // Head entry is visible whenever empty is low.
    assign empty = (count == '0);
    assign full  = (count == (ADDR_W + 1)'(DEPTH));

endmodule

// File: flit_ingress.sv
`timescale 1ns/1ps

module flit_ingress #(
    parameter int NUM_VCS = 4
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       in_valid,
    input  logic [$clog2(NUM_VCS)-1:0] in_vc,
    input  flit_pkg::flit_t            in_flit,
    output logic [NUM_VCS-1:0]         wen,
    output flit_pkg::flit_t            wdata
);

    localparam int VC_W = $clog2(NUM_VCS);

    logic            valid_q;
    logic [VC_W-1:0] vc_q;
    flit_pkg::flit_t flit_q;
    logic            vc_ok;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Channel and flit are only looked at while valid_q is high.
    always_ff @(posedge CLK) begin
        if (in_valid) begin
            vc_q   <= in_vc;
            flit_q <= in_flit;
        end
    end

    // With a NUM_VCS that is not a power of two some indices name no channel.
    assign vc_ok = (int'(vc_q) < NUM_VCS);

    always_comb begin
        wen = '0;
        if (valid_q && vc_ok) begin
            wen[vc_q] = 1'b1;
        end
    end

    assign wdata = flit_q; // Shared by all channels, the strobe picks the FIFO.

endmodule

// File: vc_buffers.sv
`timescale 1ns/1ps

module vc_buffers #(
    parameter int NUM_VCS = 4,
    parameter int DEPTH   = 16
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic [NUM_VCS-1:0] wen,
    input  flit_pkg::flit_t    wdata,
    input  logic [NUM_VCS-1:0] ren,
    output flit_pkg::flit_t    rdata [NUM_VCS],
    output logic [NUM_VCS-1:0] empty,
    output logic [NUM_VCS-1:0] valid
);

    localparam int LEN_W = flit_pkg::PKT_LENGTH_WIDTH;
    localparam int PKT_W = $clog2(DEPTH) + 1;

    logic [NUM_VCS-1:0][LEN_W-1:0] wr_cnt;
    logic [NUM_VCS-1:0][LEN_W-1:0] wr_len;
    logic [NUM_VCS-1:0][LEN_W-1:0] rd_cnt;
    logic [NUM_VCS-1:0][LEN_W-1:0] rd_len;
    logic [NUM_VCS-1:0][PKT_W-1:0] pkt_cnt; // Packets with a stored head, not yet drained.
    logic [NUM_VCS-1:0]            rd_take;
    logic [NUM_VCS-1:0]            head_in;
    logic [NUM_VCS-1:0]            tail_out;

    for (genvar i = 0; i < NUM_VCS; i++) begin : g_vc
        flit_fifo #(
            .DEPTH(DEPTH)
        ) u_fifo (
            .CLK  (CLK),
            .nRST (nRST),
            .wen  (wen[i]),
            .ren  (ren[i]),
            .wdata(wdata),
            .rdata(rdata[i]),
            .empty(empty[i]),
            .full ()
        );
    end

    always_comb begin
        for (int j = 0; j < NUM_VCS; j++) begin
            rd_take[j] = ren[j] && !empty[j];
            head_in[j] = wen[j] && (wr_cnt[j] == '0);
            if (rd_cnt[j] == '0) begin
                tail_out[j] = rd_take[j] && (flit_pkg::expected_num_flits(rdata[j]) == LEN_W'(1));
            end else begin
                tail_out[j] = rd_take[j] && (rd_cnt[j] == rd_len[j] - 1'b1);
            end
            valid[j] = (pkt_cnt[j] != '0);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_cnt  <= '0;
            wr_len  <= '0;
            rd_cnt  <= '0;
            rd_len  <= '0;
            pkt_cnt <= '0;
        end else begin
            for (int j = 0; j < NUM_VCS; j++) begin
                if (head_in[j]) begin
                    wr_len[j] <= flit_pkg::expected_num_flits(wdata);
                    if (flit_pkg::expected_num_flits(wdata) != LEN_W'(1)) begin
                        wr_cnt[j] <= LEN_W'(1);
                    end
                end else if (wen[j]) begin
                    wr_cnt[j] <= (wr_cnt[j] == wr_len[j] - 1'b1) ? '0 : wr_cnt[j] + 1'b1;
                end

                // The read side keeps its own count, so the next packet can queue behind.
                if (tail_out[j]) begin
                    rd_cnt[j] <= '0;
                end else if (rd_take[j] && rd_cnt[j] == '0) begin
                    rd_len[j] <= flit_pkg::expected_num_flits(rdata[j]);
                    rd_cnt[j] <= LEN_W'(1);
                end else if (rd_take[j]) begin
                    rd_cnt[j] <= rd_cnt[j] + 1'b1;
                end

                case ({head_in[j], tail_out[j]})
                    2'b10:   pkt_cnt[j] <= pkt_cnt[j] + 1'b1;
                    2'b01:   pkt_cnt[j] <= pkt_cnt[j] - 1'b1;
                    default: pkt_cnt[j] <= pkt_cnt[j];
                endcase
            end
        end
    end

endmodule

// File: packet_egress.sv
`timescale 1ns/1ps

module packet_egress #(
    parameter int                  NUM_VCS = 4,
    parameter route_pkg::node_id_t NODE_ID = 4'd5
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic [NUM_VCS-1:0]         valid,
    input  logic [NUM_VCS-1:0]         empty,
    input  flit_pkg::flit_t            rdata [NUM_VCS],
    output logic [NUM_VCS-1:0]         ren,
    input  logic                       out_ready,
    output logic                       out_valid,
    output flit_pkg::flit_t            out_flit,
    output logic [$clog2(NUM_VCS)-1:0] out_vc,
    output route_pkg::out_port_t       out_port,
    output logic                       out_head,
    output logic                       out_tail,
    output logic [NUM_VCS-1:0]         credit_return
);

    localparam int VC_W  = $clog2(NUM_VCS);
    localparam int LEN_W = flit_pkg::PKT_LENGTH_WIDTH;

    logic             busy;      // Locked onto cur_vc until its tail is pulled.
    logic [VC_W-1:0]  cur_vc;
    logic [VC_W-1:0]  rr_ptr;    // First channel looked at in the next arbitration.
    logic [LEN_W-1:0] remaining; // Zero means the next pull is a head.
    logic             grant_found;
    logic [VC_W-1:0]  grant_vc;
    logic             pull;
    logic             pull_head;
    logic             pull_tail;
    logic [LEN_W-1:0] head_len;

    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_vc    = '0;
        for (int k = 0; k < NUM_VCS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_VCS;
            if (!grant_found && valid[idx]) begin
                grant_found = 1'b1;
                grant_vc    = VC_W'(idx);
            end
        end
    end

    // One flit moves when the output register is free or draining this cycle.
    assign pull      = busy && (!out_valid || out_ready) && !empty[cur_vc];
    assign pull_head = (remaining == '0);
    assign head_len  = flit_pkg::expected_num_flits(rdata[cur_vc]);
    assign pull_tail = pull_head ? (head_len == LEN_W'(1)) : (remaining == LEN_W'(1));

    always_comb begin
        ren = '0;
        if (pull) begin
            ren[cur_vc] = 1'b1;
        end
    end

    assign credit_return = ren; // Each flit read frees one slot upstream.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy      <= 1'b0;
            cur_vc    <= '0;
            rr_ptr    <= '0;
            remaining <= '0;
            out_valid <= 1'b0;
        end else begin
            if (!busy && grant_found) begin
                busy   <= 1'b1;
                cur_vc <= grant_vc;
                rr_ptr <= (int'(grant_vc) == NUM_VCS - 1) ? '0 : grant_vc + 1'b1;
            end else if (pull && pull_tail) begin
                busy <= 1'b0; // The next cycle is the arbitration step.
            end

            if (pull) begin
                remaining <= pull_head ? head_len - 1'b1 : remaining - 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (pull) begin
            out_flit <= rdata[cur_vc];
            out_vc   <= cur_vc;
            out_head <= pull_head;
            out_tail <= pull_tail;
            if (pull_head) begin
                out_port <= route_pkg::route_port(rdata[cur_vc].head.dest, NODE_ID);
            end
        end
    end

endmodule

// File: chiplet_input_port.sv
`timescale 1ns/1ps

module chiplet_input_port #(
    parameter int                  NUM_VCS = 4,
    parameter int                  DEPTH   = 16,
    parameter route_pkg::node_id_t NODE_ID = 4'd5
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       in_valid,
    input  logic [$clog2(NUM_VCS)-1:0] in_vc,
    input  flit_pkg::flit_t            in_flit,
    input  logic                       out_ready,
    output logic                       out_valid,
    output flit_pkg::flit_t            out_flit,
    output logic [$clog2(NUM_VCS)-1:0] out_vc,
    output route_pkg::out_port_t       out_port,
    output logic                       out_head,
    output logic                       out_tail,
    output logic [NUM_VCS-1:0]         credit_return
);

    logic [NUM_VCS-1:0] wen;
    flit_pkg::flit_t    wdata;
    logic [NUM_VCS-1:0] ren;
    flit_pkg::flit_t    rdata [NUM_VCS];
    logic [NUM_VCS-1:0] empty;
    logic [NUM_VCS-1:0] valid;

    flit_ingress #(
        .NUM_VCS(NUM_VCS)
    ) u_ingress (
        .CLK     (CLK),
        .nRST    (nRST),
        .in_valid(in_valid),
        .in_vc   (in_vc),
        .in_flit (in_flit),
        .wen     (wen),
        .wdata   (wdata)
    );

    vc_buffers #(
        .NUM_VCS(NUM_VCS),
        .DEPTH  (DEPTH)
    ) u_buffers (
        .CLK  (CLK),
        .nRST (nRST),
        .wen  (wen),
        .wdata(wdata),
        .ren  (ren),
        .rdata(rdata),
        .empty(empty),
        .valid(valid)
    );

    packet_egress #(
        .NUM_VCS(NUM_VCS),
        .NODE_ID(NODE_ID)
    ) u_egress (
        .CLK          (CLK),
        .nRST         (nRST),
        .valid        (valid),
        .empty        (empty),
        .rdata        (rdata),
        .ren          (ren),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_flit     (out_flit),
        .out_vc       (out_vc),
        .out_port     (out_port),
        .out_head     (out_head),
        .out_tail     (out_tail),
        .credit_return(credit_return)
    );

endmodule

// File: tb_chiplet_input_port.sv
`timescale 1ns/1ps

module tb_chiplet_input_port;

    localparam int                  NUM_VCS    = 4;
    localparam int                  DEPTH      = 16;
    localparam route_pkg::node_id_t NODE_ID    = 4'd5;
    localparam int                  VC_W       = $clog2(NUM_VCS);
    localparam int                  WAIT_LIMIT = 4000;

    logic                 CLK;
    logic                 nRST;
    logic                 in_valid;
    logic [VC_W-1:0]      in_vc;
    flit_pkg::flit_t      in_flit;
    logic                 out_ready;
    logic                 out_valid;
    flit_pkg::flit_t      out_flit;
    logic [VC_W-1:0]      out_vc;
    route_pkg::out_port_t out_port;
    logic                 out_head;
    logic                 out_tail;
    logic [NUM_VCS-1:0]   credit_return;

    flit_pkg::flit_t exp_flit [NUM_VCS][$];
    logic [1:0]      exp_mark [NUM_VCS][$]; // Head and tail bits of each expected flit.
    int              sent [NUM_VCS];
    int              returned [NUM_VCS];
    int              transferred [NUM_VCS];
    string           test_name;
    int              bp_mode;               // 0 ready, 1 random stalls, 2 held low.
    logic            in_pkt;
    logic [VC_W-1:0] pkt_vc;
    logic            stalled;
    flit_pkg::flit_t held_flit;

    chiplet_input_port #(
        .NUM_VCS(NUM_VCS),
        .DEPTH  (DEPTH),
        .NODE_ID(NODE_ID)
    ) UUT (
        .CLK(CLK), .nRST(nRST), .in_valid(in_valid), .in_vc(in_vc), .in_flit(in_flit),
        .out_ready(out_ready), .out_valid(out_valid), .out_flit(out_flit), .out_vc(out_vc),
        .out_port(out_port), .out_head(out_head), .out_tail(out_tail),
        .credit_return(credit_return)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_flit(input string what, input flit_pkg::flit_t exp,
                              input flit_pkg::flit_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s %s: expected %h, actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_port(input string what, input route_pkg::out_port_t exp,
                              input route_pkg::out_port_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act));
        end
    endtask

    task automatic check_bits(input string what, input logic [NUM_VCS-1:0] exp,
                              input logic [NUM_VCS-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s %s: expected %b, actual %b", test_name, what, exp, act));
        end
    endtask

    // Nodes sit on a line. An equal id stays local, higher ids go east and lower ids go west.
    function automatic route_pkg::out_port_t expected_port(input route_pkg::node_id_t dest);
        if (dest == NODE_ID) return route_pkg::PORT_LOCAL;
        if (dest > NODE_ID) return route_pkg::PORT_EAST;
        return route_pkg::PORT_WEST;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic flit_pkg::flit_t make_head(input route_pkg::node_id_t dest, input int len);
        flit_pkg::flit_t f;
        f.body.data   = $urandom(); // Leaves a random tag behind the named fields.
        f.head.dest   = dest;
        f.head.src    = route_pkg::node_id_t'($urandom);
        f.head.length = flit_pkg::pkt_len_t'(len);
        return f;
    endfunction

    function automatic flit_pkg::flit_t make_body();
        flit_pkg::flit_t f;
        f.body.data = $urandom();
        return f;
    endfunction

    function automatic bit queues_empty();
        for (int k = 0; k < NUM_VCS; k++) begin
            if (exp_flit[k].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge CLK);
    endtask

    task automatic send_flit(input int vc, input flit_pkg::flit_t f, input logic head,
                             input logic tail);
        int n;
        n = 0;
        while (DEPTH - sent[vc] + returned[vc] == 0) begin // Link source honors credits.
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT) stop_run("Timed out waiting for a credit to come back.");
        end
        in_valid = 1'b1;
        in_vc    = VC_W'(vc);
        in_flit  = f;
        sent[vc]++;
        exp_flit[vc].push_back(f);
        exp_mark[vc].push_back({head, tail});
        @(negedge CLK);
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int vc, input route_pkg::node_id_t dest, input int len,
                               input int gap_max);
        flit_pkg::flit_t head;
        int              n;
        head = make_head(dest, len);
        n    = int'(flit_pkg::expected_num_flits(head));
        send_flit(vc, head, 1'b1, n == 1);
        for (int i = 1; i < n; i++) begin
            if (gap_max > 0) idle(rand_range(0, gap_max));
            send_flit(vc, make_body(), 1'b0, i == n - 1);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (!queues_empty() || out_valid) begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT) stop_run("Timed out waiting for the expected flits to leave.");
        end
        idle(2);
    endtask

    task automatic check_transfer();
        int              vc;
        flit_pkg::flit_t exp;
        logic [1:0]      mark;
        vc = int'(out_vc);
        if (exp_flit[vc].size() == 0) begin
            stop_run($sformatf("A flit left on channel %0d while none was expected there.", vc));
        end else begin
            exp  = exp_flit[vc].pop_front();
            mark = exp_mark[vc].pop_front();
            check_flit("out_flit", exp, out_flit);
            check_bits("out_head", NUM_VCS'(mark[1]), NUM_VCS'(out_head));
            check_bits("out_tail", NUM_VCS'(mark[0]), NUM_VCS'(out_tail));
            if (mark[1]) begin
                check_port("out_port", expected_port(exp.head.dest), out_port);
                check_bits("head while a packet is open", '0, NUM_VCS'(in_pkt));
                in_pkt = 1'b1;
                pkt_vc = out_vc;
            end else begin
                check_bits("out_vc inside a packet", NUM_VCS'(pkt_vc), NUM_VCS'(out_vc));
            end
            if (mark[0]) in_pkt = 1'b0;
            transferred[vc]++;
        end
    endtask

    always @(posedge CLK) begin
        if (!nRST) begin
            in_pkt  = 1'b0;
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                check_bits("out_valid under stall", NUM_VCS'(1'b1), NUM_VCS'(out_valid));
                check_flit("out_flit under stall", held_flit, out_flit);
            end
            if (out_valid && !out_ready) check_bits("credit_return under stall", '0, credit_return);
            if ($countones(credit_return) > 1) stop_run("Two channels returned a credit at once.");
            for (int k = 0; k < NUM_VCS; k++) begin
                if (credit_return[k]) returned[k]++;
            end
            if (out_valid && out_ready) check_transfer();
            stalled   = out_valid && !out_ready;
            held_flit = out_flit;
        end
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge CLK);
            case (bp_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = ($urandom % 3) != 0;
                default: out_ready = 1'b0;
            endcase
        end
    end

    initial begin
        flit_pkg::flit_t ha;
        flit_pkg::flit_t hb;
        void'($urandom(46));
        nRST      = 1'b0;
        in_valid  = 1'b0;
        in_vc     = '0;
        in_flit   = '0;
        bp_mode   = 0;
        test_name = "reset";
        for (int i = 0; i < 20; i++) begin
            @(negedge CLK);
            if (i == 15) nRST = 1'b1; // Sixteen cycles in reset, then a few idle ones.
            check_bits("out_valid", '0, NUM_VCS'(out_valid));
            check_bits("credit_return", '0, credit_return);
        end
        send_packet(0, NODE_ID, 1, 0);
        send_packet(1, 4'd12, 0, 0); // A zero length field still means one flit.
        wait_drain();

        test_name = "integrity";
        send_packet(1, NODE_ID, 4, 0);
        send_packet(1, 4'd9, 7, 0);
        send_packet(1, 4'd2, 15, 0);
        wait_drain();

        test_name = "no_interleave";
        bp_mode = 2;
        for (int p = 0; p < 2; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                send_packet(v, route_pkg::node_id_t'($urandom), rand_range(2, 6), 0);
            end
        end
        bp_mode = 0;
        wait_drain();

        test_name = "back_pressure";
        bp_mode = 1;
        repeat (12) begin
            send_packet(rand_range(0, 3), route_pkg::node_id_t'($urandom), rand_range(1, 15), 0);
        end
        wait_drain();

        test_name = "gaps";
        ha = make_head(4'd1, 5);
        hb = make_head(4'd14, 5);
        for (int i = 0; i < 5; i++) begin
            send_flit(2, (i == 0) ? ha : make_body(), i == 0, i == 4);
            idle(rand_range(1, 3));
            send_flit(3, (i == 0) ? hb : make_body(), i == 0, i == 4);
            idle(rand_range(0, 2));
        end
        send_packet(0, 4'd7, 8, 3);
        wait_drain();
        bp_mode = 0;

        test_name = "credits";
        for (int k = 0; k < NUM_VCS; k++) begin
            if (DEPTH - sent[k] + returned[k] != DEPTH) begin
                stop_run($sformatf("ERR %s vc %0d credits: expected %0d, actual %0d",
                                   test_name, k, DEPTH, DEPTH - sent[k] + returned[k]));
            end
            if (returned[k] != transferred[k]) begin
                stop_run($sformatf("ERR %s vc %0d returned: expected %0d, actual %0d",
                                   test_name, k, transferred[k], returned[k]));
            end
        end
        if (!queues_empty()) begin
            stop_run("Expected flits were still queued at the end of the run.");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: list.f
route_pkg.sv
flit_pkg.sv
flit_fifo.sv
flit_ingress.sv
vc_buffers.sv
packet_egress.sv
chiplet_input_port.sv
tb_chiplet_input_port.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_chiplet_input_port
FILELIST  := list.f
OBJDIR    := obj_dir
SIMFLAGS  := --binary --timing -j 0 --Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
